/* logic/bram_ctrl_pkg.sv */
package bram_ctrl_pkg;

    ////////////////////////////////////////
    // Sizing constants
    ////////////////////////////////////////

    // Words per BRAM
    localparam int BRAM_DEPTH = 1024;
    // Map coordinate width, half the BRAM address space
    localparam int DIM_W = $clog2(BRAM_DEPTH) - 1;
    // Fill count of the prefetch buffer
    localparam int PFB_COUNT_W = 18;

    // seq_rden pulses per output column
    localparam int CYCLES_PER_PIXEL = 5;
    // seq_rden to cycle counter step
    localparam int SEQ_RDEN_LAG = 2;
    // Internal pixel strobe to pixel_dataout_valid
    localparam int PIXEL_VALID_LAG = 3;
    // Last input row loaded before the engines start
    localparam int PRIME_LAST_ROW = 2;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PRIME,
        SEQ_WAIT_LOAD,
        SEQ_ACTIVE
    } seq_state_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_ROW
    } fetch_state_t;

    // Last index per dimension, not a count
    typedef struct packed {
        logic [DIM_W-1:0] cols;
        logic [DIM_W-1:0] rows;
        logic [DIM_W-1:0] depth;
    } map_dims_t;

    typedef struct packed {
        logic [DIM_W-1:0] row;
        logic [DIM_W-1:0] col;
        logic [DIM_W-1:0] depth;
    } map_pos_t;

    // Prefetch buffer flags as seen from the FIFO
    typedef struct packed {
        logic                   empty;
        logic [PFB_COUNT_W-1:0] count;
    } pfb_status_t;

endpackage

/* logic/bram_ctrl_top.sv */
`timescale 1ns/1ps

module bram_ctrl_top
    import bram_ctrl_pkg::*;
#(
    parameter int NUM_AWE        = 4,
    parameter int NUM_CE_PER_AWE = 2,
    parameter int PAYLOAD_WIDTH  = 128
) (
    input  logic                                clk_500MHz,
    input  logic                                accel_rst,
    input  logic                                start,
    input  map_dims_t                           dims,
    // Prefetch buffer
    input  pfb_status_t                         pfb_status,
    output logic                                pfb_rden,
    output logic                                pfb_wren,
    output logic [PAYLOAD_WIDTH-1:0]            pfb_wdata,
    // Network port
    output logic                                to_network_valid,
    input  logic                                from_network_valid,
    input  logic [PAYLOAD_WIDTH-1:0]            from_network_payload,
    output logic                                from_network_accept,
    // Compute side pulses
    input  logic                                seq_rden,
    input  logic                                next_row,
    input  logic                                row_matric,
    // Status and launch
    output seq_state_t                          state,
    output logic [NUM_AWE*NUM_CE_PER_AWE-1:0]   ce_start,
    output logic                                pixel_dataout_valid,
    output logic [2:0]                          cycle_counter,
    output logic [1:0]                          gray_code,
    output logic [DIM_W-1:0]                    wr_addr,
    output map_pos_t                            in_pos,
    output map_pos_t                            out_pos
);

    // Sequencer to fetch handshake
    logic row_request;
    logic fetch_busy;
    // Output row end from the position tracker
    logic out_row_done;
    // Active phase strobe, before the valid lag
    logic pixel_strobe;

    pixel_sequencer i_pixel_sequencer (
        .clk_500MHz   (clk_500MHz),
        .accel_rst    (accel_rst),
        .start        (start),
        .dims         (dims),
        .pfb_status   (pfb_status),
        .fetch_busy   (fetch_busy),
        .row_matric   (row_matric),
        .in_pos       (in_pos),
        .out_pos      (out_pos),
        .out_row_done (out_row_done),
        .state        (state),
        .pfb_rden     (pfb_rden),
        .row_request  (row_request),
        .pixel_strobe (pixel_strobe),
        .wr_addr      (wr_addr)
    );

    row_fetch #(
        .PAYLOAD_WIDTH (PAYLOAD_WIDTH)
    ) i_row_fetch (
        .clk_500MHz           (clk_500MHz),
        .accel_rst            (accel_rst),
        .row_request          (row_request),
        .dims                 (dims),
        .pfb_status           (pfb_status),
        .from_network_valid   (from_network_valid),
        .from_network_payload (from_network_payload),
        .to_network_valid     (to_network_valid),
        .from_network_accept  (from_network_accept),
        .pfb_wren             (pfb_wren),
        .pfb_wdata            (pfb_wdata),
        .fetch_busy           (fetch_busy)
    );

    map_position i_map_position (
        .clk_500MHz    (clk_500MHz),
        .accel_rst     (accel_rst),
        .dims          (dims),
        .state         (state),
        .pfb_rden      (pfb_rden),
        .seq_rden      (seq_rden),
        .next_row      (next_row),
        .in_pos        (in_pos),
        .out_pos       (out_pos),
        .out_row_done  (out_row_done),
        .cycle_counter (cycle_counter),
        .gray_code     (gray_code)
    );

    ce_launch_stagger #(
        .NUM_AWE        (NUM_AWE),
        .NUM_CE_PER_AWE (NUM_CE_PER_AWE)
    ) i_ce_launch_stagger (
        .clk_500MHz          (clk_500MHz),
        .accel_rst           (accel_rst),
        .state               (state),
        .pixel_strobe        (pixel_strobe),
        .ce_start            (ce_start),
        .pixel_dataout_valid (pixel_dataout_valid)
    );

endmodule

/* logic/ce_launch_stagger.sv */
`timescale 1ns/1ps

module ce_launch_stagger
    import bram_ctrl_pkg::*;
#(
    parameter int NUM_AWE        = 4,
    parameter int NUM_CE_PER_AWE = 2
) (
    input  logic                              clk_500MHz,
    input  logic                              accel_rst,
    input  seq_state_t                        state,
    input  logic                              pixel_strobe,
    output logic [NUM_AWE*NUM_CE_PER_AWE-1:0] ce_start,
    output logic                              pixel_dataout_valid
);

    localparam int CE_COUNT = NUM_AWE * NUM_CE_PER_AWE;

    logic [PIXEL_VALID_LAG-1:0] valid_pipe;

    // Engine k starts k+1 cycles into the active phase
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            ce_start <= '0;
        end else begin
            ce_start[0] <= (state == SEQ_ACTIVE);
            for (int k = 1; k < CE_COUNT; k++) begin
                ce_start[k] <= ce_start[k-1];
            end
        end
    end

    // Valid trails the strobe by the BRAM read path
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[PIXEL_VALID_LAG-2:0], pixel_strobe};
        end
    end

    assign pixel_dataout_valid = valid_pipe[PIXEL_VALID_LAG-1];

endmodule

/* logic/map_position.sv */
`timescale 1ns/1ps

module map_position
    import bram_ctrl_pkg::*;
(
    input  logic       clk_500MHz,
    input  logic       accel_rst,
    input  map_dims_t  dims,
    input  seq_state_t state,
    input  logic       pfb_rden,
    input  logic       seq_rden,
    input  logic       next_row,
    output map_pos_t   in_pos,
    output map_pos_t   out_pos,
    output logic       out_row_done,
    output logic [2:0] cycle_counter,
    output logic [1:0] gray_code
);

    logic [SEQ_RDEN_LAG-1:0] seq_rden_d;
    logic                    cycle_step;
    logic                    cycle_wrap;
    logic [DIM_W-1:0]        last_out_row;
    logic [1:0]              row_slot;

    assign last_out_row = dims.rows - DIM_W'(PRIME_LAST_ROW);

    ////////////////////////////////////////
    // Input position, one step per pfb read
    ////////////////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst || state == SEQ_IDLE) begin
            in_pos <= '0;
        end else if (pfb_rden) begin
            if (in_pos.col == dims.cols) begin
                in_pos.col <= '0;
                if (in_pos.row == dims.rows) begin
                    in_pos.row   <= '0;
                    in_pos.depth <= (in_pos.depth == dims.depth) ? '0 : in_pos.depth + 1'b1;
                end else begin
                    in_pos.row <= in_pos.row + 1'b1;
                end
            end else begin
                in_pos.col <= in_pos.col + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Cycle counter and output position
    ////////////////////////////////////////

    // Line up seq_rden with the engine read
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            seq_rden_d <= '0;
        end else begin
            seq_rden_d <= {seq_rden_d[SEQ_RDEN_LAG-2:0], seq_rden};
        end
    end

    assign cycle_step   = seq_rden_d[SEQ_RDEN_LAG-1] && (state == SEQ_ACTIVE);
    assign cycle_wrap   = cycle_step && (cycle_counter == 3'(CYCLES_PER_PIXEL - 1));
    // Last column of the output row finishing
    assign out_row_done = cycle_wrap && (out_pos.col == dims.cols);

    // Modulo five, one pixel per wrap
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            cycle_counter <= '0;
        end else if (cycle_step) begin
            cycle_counter <= cycle_wrap ? 3'd0 : cycle_counter + 3'd1;
        end
    end

    always_ff @(posedge clk_500MHz) begin
        if (accel_rst || state == SEQ_IDLE) begin
            out_pos <= '0;
        end else if (cycle_wrap) begin
            if (out_row_done) begin
                out_pos.col <= '0;
                if (out_pos.row == last_out_row) begin
                    out_pos.row <= '0;
                    // Depth holds at the last slice
                    if (out_pos.depth != dims.depth) begin
                        out_pos.depth <= out_pos.depth + 1'b1;
                    end
                end else begin
                    out_pos.row <= out_pos.row + 1'b1;
                end
            end else begin
                out_pos.col <= out_pos.col + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Gray coded row slot
    ////////////////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            row_slot <= '0;
        end else if (next_row) begin
            row_slot <= row_slot + 2'd1;
        end
    end

    assign gray_code = {row_slot[1], row_slot[1] ^ row_slot[0]};

endmodule

/* logic/pixel_sequencer.sv */
`timescale 1ns/1ps

module pixel_sequencer
    import bram_ctrl_pkg::*;
(
    input  logic             clk_500MHz,
    input  logic             accel_rst,
    input  logic             start,
    input  map_dims_t        dims,
    input  pfb_status_t      pfb_status,
    input  logic             fetch_busy,
    input  logic             row_matric,
    input  map_pos_t         in_pos,
    input  map_pos_t         out_pos,
    input  logic             out_row_done,
    output seq_state_t       state,
    output logic             pfb_rden,
    output logic             row_request,
    output logic             pixel_strobe,
    output logic [DIM_W-1:0] wr_addr
);

    // State to go back to once a row is loaded
    seq_state_t       resume_state;
    logic             row_loaded;
    logic             read_ok;
    logic             prime_done;
    logic             run_done;
    logic [DIM_W-1:0] last_out_row;

    // A full row sits in the pfb
    assign row_loaded = (pfb_status.count >= PFB_COUNT_W'(dims.cols));

    // Never pop the last word twice
    assign read_ok = !pfb_status.empty
                  && !(pfb_status.count == PFB_COUNT_W'(1) && pfb_rden);

    // Final read of the last prime row under way
    assign prime_done = pfb_rden
                     && in_pos.row == DIM_W'(PRIME_LAST_ROW)
                     && in_pos.col == dims.cols;

    // 3x3 window, output rows end PRIME_LAST_ROW short
    assign last_out_row = dims.rows - DIM_W'(PRIME_LAST_ROW);
    assign run_done     = out_pos.depth == dims.depth && out_pos.row == last_out_row;

    ////////////////////////////////////////
    // Main FSM
    ////////////////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            state        <= SEQ_IDLE;
            resume_state <= SEQ_IDLE;
            pfb_rden     <= 1'b0;
            row_request  <= 1'b0;
            pixel_strobe <= 1'b0;
            wr_addr      <= '0;
        end else begin
            // Strobes default low
            pfb_rden     <= 1'b0;
            row_request  <= 1'b0;
            pixel_strobe <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_PRIME;
                    end
                end
                SEQ_PRIME: begin
                    // Fill the first rows of the window
                    if (prime_done) begin
                        state <= SEQ_ACTIVE;
                    end else if (pfb_status.empty) begin
                        resume_state <= SEQ_PRIME;
                        state        <= SEQ_WAIT_LOAD;
                    end else begin
                        pfb_rden <= read_ok;
                    end
                end
                SEQ_WAIT_LOAD: begin
                    if (row_loaded) begin
                        state <= resume_state;
                    end else if (!fetch_busy) begin
                        row_request <= 1'b1;
                    end
                end
                SEQ_ACTIVE: begin
                    pixel_strobe <= !out_row_done;
                    // Fetch ahead while the engines run
                    if (!row_loaded && !fetch_busy) begin
                        row_request <= 1'b1;
                    end
                    // Next row into the window
                    if (row_matric) begin
                        pfb_rden <= read_ok;
                        wr_addr  <= wr_addr + 1'b1;
                    end
                    if (out_row_done) begin
                        if (run_done) begin
                            state <= SEQ_IDLE;
                        end else if (!row_loaded) begin
                            resume_state <= SEQ_ACTIVE;
                            state        <= SEQ_WAIT_LOAD;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

/* logic/row_fetch.sv */
`timescale 1ns/1ps

module row_fetch
    import bram_ctrl_pkg::*;
#(
    parameter int PAYLOAD_WIDTH = 128
) (
    input  logic                     clk_500MHz,
    input  logic                     accel_rst,
    input  logic                     row_request,
    input  map_dims_t                dims,
    input  pfb_status_t              pfb_status,
    input  logic                     from_network_valid,
    input  logic [PAYLOAD_WIDTH-1:0] from_network_payload,
    output logic                     to_network_valid,
    output logic                     from_network_accept,
    output logic                     pfb_wren,
    output logic [PAYLOAD_WIDTH-1:0] pfb_wdata,
    output logic                     fetch_busy
);

    fetch_state_t fetch_state;
    logic         take_beat;

    // Beats only land while a row is open
    assign take_beat = (fetch_state == FETCH_ROW) && from_network_valid;

    // Busy already in the request cycle
    assign fetch_busy = row_request || (fetch_state == FETCH_ROW);

    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            fetch_state         <= FETCH_IDLE;
            to_network_valid    <= 1'b0;
            from_network_accept <= 1'b0;
            pfb_wren            <= 1'b0;
        end else begin
            to_network_valid    <= 1'b0;
            from_network_accept <= take_beat;
            pfb_wren            <= take_beat;
            case (fetch_state)
                FETCH_IDLE: begin
                    // One network request per row
                    if (row_request) begin
                        to_network_valid <= 1'b1;
                        fetch_state      <= FETCH_ROW;
                    end
                end
                FETCH_ROW: begin
                    if (pfb_status.count == PFB_COUNT_W'(dims.cols)) begin
                        fetch_state <= FETCH_IDLE;
                    end
                end
                default: fetch_state <= FETCH_IDLE;
            endcase
        end
    end

    // Payload, aligned with pfb_wren
    always_ff @(posedge clk_500MHz) begin
        if (take_beat) begin
            pfb_wdata <= from_network_payload;
        end
    end

endmodule

/* tb.f */
logic/bram_ctrl_pkg.sv
logic/pixel_sequencer.sv
logic/row_fetch.sv
logic/map_position.sv
logic/ce_launch_stagger.sv
logic/bram_ctrl_top.sv
tb/bram_ctrl_tb.sv

/* tb/bram_ctrl_tb.sv */
`timescale 1ns/1ps

module bram_ctrl_tb
    import bram_ctrl_pkg::*;
();

    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int PAYLOAD_WIDTH  = 128;
    localparam int CE_COUNT       = NUM_AWE * NUM_CE_PER_AWE;
    localparam int T_COLS         = 7;
    localparam int T_ROWS         = 5;
    localparam int T_DEPTH        = 1;
    // Cycles before the watchdog gives up
    localparam int RUN_LIMIT = 40 * (T_ROWS + 1) * (T_COLS + 1) * (T_DEPTH + 1) * CYCLES_PER_PIXEL;
    // Output columns over the whole map
    localparam int EXP_WRAPS = (T_DEPTH + 1) * (T_ROWS - PRIME_LAST_ROW + 1) * (T_COLS + 1);

    logic                              clk_500MHz;
    logic                              accel_rst;
    logic                              start;
    map_dims_t                         dims;
    pfb_status_t                       pfb_status;
    logic                              pfb_rden;
    logic                              pfb_wren;
    logic [PAYLOAD_WIDTH-1:0]          pfb_wdata;
    logic                              to_network_valid;
    logic                              from_network_valid;
    logic [PAYLOAD_WIDTH-1:0]          from_network_payload;
    logic                              from_network_accept;
    logic                              seq_rden;
    logic                              next_row;
    logic                              row_matric;
    seq_state_t                        state;
    logic [CE_COUNT-1:0]               ce_start;
    logic                              pixel_dataout_valid;
    logic [2:0]                        cycle_counter;
    logic [1:0]                        gray_code;
    logic [DIM_W-1:0]                  wr_addr;
    map_pos_t                          in_pos;
    map_pos_t                          out_pos;

    // Prefetch buffer model
    logic [PAYLOAD_WIDTH-1:0] pfb_q[$];
    int mismatch_errs = 0;
    int other_errs    = 0;
    int pfb_reads     = 0;
    int pfb_writes    = 0;
    int accepted      = 0;
    bit run_finished  = 0;

    bram_ctrl_top #(
        .NUM_AWE        (NUM_AWE),
        .NUM_CE_PER_AWE (NUM_CE_PER_AWE),
        .PAYLOAD_WIDTH  (PAYLOAD_WIDTH)
    ) i_dut (.*);

    ////////////////////////////////////////
    // Reference functions
    ////////////////////////////////////////

    function automatic logic [1:0] gray_of(input int n);
        logic [1:0] b;
        b = n[1:0];
        return b ^ (b >> 1);
    endfunction

    function automatic int cycle_next(input int c);
        return (c == CYCLES_PER_PIXEL - 1) ? 0 : c + 1;
    endfunction

    function automatic int index_next(input int c, input int last);
        return (c == last) ? 0 : c + 1;
    endfunction

    // Column first, then row, then depth
    function automatic map_pos_t in_pos_next(input map_pos_t p);
        map_pos_t n;
        n     = p;
        n.col = DIM_W'(index_next(p.col, T_COLS));
        if (p.col == DIM_W'(T_COLS)) begin
            n.row = DIM_W'(index_next(p.row, T_ROWS));
            if (p.row == DIM_W'(T_ROWS))
                n.depth = DIM_W'(index_next(p.depth, T_DEPTH));
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        mismatch_errs++;
        $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    task automatic check_cleared(input string name, input logic [127:0] got);
        if (got !== '0)
            report_mismatch(name, got, '0);
    endtask

    initial begin
        clk_500MHz = 1'b0;
        forever #5 clk_500MHz = ~clk_500MHz;
    end

    ////////////////////////////////////////
    // Stimulus, pfb and network model
    ////////////////////////////////////////
    initial begin
        int                       beats_left;
        logic [PAYLOAD_WIDTH-1:0] beat;
        void'($urandom(32'h1f1d719c));
        accel_rst            = 1'b1;
        start                = 1'b0;
        dims                 = '{cols: DIM_W'(T_COLS), rows: DIM_W'(T_ROWS), depth: DIM_W'(T_DEPTH)};
        pfb_status           = '{empty: 1'b1, count: '0};
        from_network_valid   = 1'b0;
        from_network_payload = '0;
        seq_rden             = 1'b0;
        next_row             = 1'b0;
        row_matric           = 1'b0;
        beats_left           = 0;
        beat                 = {$urandom, $urandom, $urandom, $urandom};
        repeat (2) @(posedge clk_500MHz);
        #1;
        // Outputs idle during reset
        check_cleared("pfb_rden", pfb_rden);
        check_cleared("pfb_wren", pfb_wren);
        check_cleared("to_network_valid", to_network_valid);
        check_cleared("from_network_accept", from_network_accept);
        check_cleared("ce_start", ce_start);
        check_cleared("pixel_dataout_valid", pixel_dataout_valid);
        check_cleared("cycle_counter", cycle_counter);
        check_cleared("gray_code", gray_code);
        check_cleared("wr_addr", wr_addr);
        check_cleared("state", state);
        accel_rst = 1'b0;
        start     = 1'b1;
        forever begin
            @(posedge clk_500MHz);
            #1;
            start = 1'b0;
            // Beat sampled at this edge was taken
            if (from_network_accept) begin
                if (!pfb_wren)
                    report_failure("accepted beat without pfb write");
                if (pfb_wdata !== beat)
                    report_mismatch("pfb_wdata", pfb_wdata, beat);
                accepted++;
                beats_left--;
                beat = {$urandom, $urandom, $urandom, $urandom};
            end
            if (to_network_valid)
                beats_left += T_COLS + 1;
            // Pop on read, push on write
            if (pfb_rden) begin
                pfb_reads++;
                if (pfb_q.size() == 0)
                    report_failure("pfb read while the buffer is empty");
                else
                    void'(pfb_q.pop_front());
            end
            if (pfb_wren) begin
                pfb_writes++;
                pfb_q.push_back(pfb_wdata);
            end
            pfb_status = '{empty: (pfb_q.size() == 0), count: PFB_COUNT_W'(pfb_q.size())};
            // Random gaps, payload held until taken
            from_network_valid   = (beats_left > 0) && ($urandom % 4 != 0);
            from_network_payload = beat;
            seq_rden             = $urandom % 2;
            next_row             = ($urandom % 8 == 0);
            row_matric           = ($urandom % 16 == 0);
        end
    end

    ////////////////////////////////////////
    // Model update and comparison
    ////////////////////////////////////////
    always @(negedge clk_500MHz) begin : compare
        static bit         outstanding = 0;
        static bit         seen_active = 0;
        static bit         rden_hist[0:3];
        static bit         act_hist[0:CE_COUNT];
        static bit         strobe_hist[0:3];
        static seq_state_t prev_state = SEQ_IDLE;
        static int         exp_cc = 0;
        static int         exp_col = 0;
        static int         exp_row = 0;
        static map_pos_t   exp_in = '0;
        static int         wraps = 0;
        static int         next_rows = 0;
        static int         matrics = 0;
        static int         seen_count = 0;
        static bit         prev_next_row = 0;
        static bit         prev_row_matric = 0;
        static bit         prev_pfb_rden = 0;
        logic [CE_COUNT-1:0] exp_ce;
        bit                  wrap;
        bit                  row_end;
        if (!accel_rst) begin
            // Request only with no fetch open
            if (to_network_valid) begin
                if (outstanding)
                    report_failure("network request while a fetch is outstanding");
                outstanding = 1;
            end else if (outstanding && seen_count == T_COLS) begin
                outstanding = 0;
            end

            for (int j = 3; j > 0; j--) begin
                rden_hist[j]   = rden_hist[j-1];
                strobe_hist[j] = strobe_hist[j-1];
            end
            for (int j = CE_COUNT; j > 0; j--)
                act_hist[j] = act_hist[j-1];
            rden_hist[0] = seq_rden;
            act_hist[0]  = (state == SEQ_ACTIVE);

            // Counter steps on seq_rden two edges back
            wrap = 0;
            if (rden_hist[3] && prev_state == SEQ_ACTIVE) begin
                wrap   = (exp_cc == CYCLES_PER_PIXEL - 1);
                exp_cc = cycle_next(exp_cc);
            end
            if (cycle_counter != 3'(exp_cc))
                report_mismatch("cycle_counter", cycle_counter, exp_cc);

            // Strobe held while active, dropped after the last column of a row
            row_end        = wrap && (exp_col == T_COLS);
            strobe_hist[0] = (prev_state == SEQ_ACTIVE) && !row_end;
            if (prev_state == SEQ_IDLE) begin
                exp_col = 0;
                exp_row = 0;
            end else if (wrap) begin
                wraps++;
                exp_col = index_next(exp_col, T_COLS);
                if (row_end)
                    exp_row = index_next(exp_row, T_ROWS - PRIME_LAST_ROW);
            end
            if (out_pos.col != DIM_W'(exp_col))
                report_mismatch("out_pos.col", out_pos.col, exp_col);
            if (out_pos.row != DIM_W'(exp_row))
                report_mismatch("out_pos.row", out_pos.row, exp_row);

            // Input position follows the pfb reads
            if (prev_state == SEQ_IDLE)
                exp_in = '0;
            else if (prev_pfb_rden)
                exp_in = in_pos_next(exp_in);
            if (in_pos != exp_in)
                report_mismatch("in_pos", in_pos, exp_in);

            for (int k = 0; k < CE_COUNT; k++)
                exp_ce[k] = act_hist[k+1];
            if (ce_start != exp_ce)
                report_mismatch("ce_start", ce_start, exp_ce);
            if (pixel_dataout_valid != strobe_hist[3])
                report_mismatch("pixel_dataout_valid", pixel_dataout_valid, strobe_hist[3]);

            if (prev_next_row)
                next_rows++;
            if (gray_code != gray_of(next_rows))
                report_mismatch("gray_code", gray_code, gray_of(next_rows));
            if (prev_row_matric && prev_state == SEQ_ACTIVE)
                matrics++;
            if (wr_addr != DIM_W'(matrics))
                report_mismatch("wr_addr", wr_addr, DIM_W'(matrics));

            // Priming must load the first window rows
            if (!seen_active && state == SEQ_ACTIVE) begin
                seen_active = 1;
                if (pfb_reads < (PRIME_LAST_ROW + 1) * (T_COLS + 1))
                    report_failure("active phase entered before the window was loaded");
            end
            if (prev_state != SEQ_IDLE && state == SEQ_IDLE && !run_finished) begin
                if (out_pos.depth != DIM_W'(T_DEPTH))
                    report_mismatch("out_pos.depth", out_pos.depth, T_DEPTH);
                if (wraps != EXP_WRAPS)
                    report_mismatch("output column count", wraps, EXP_WRAPS);
                run_finished = 1;
            end

            prev_state      = state;
            prev_next_row   = next_row;
            prev_row_matric = row_matric;
            prev_pfb_rden   = pfb_rden;
            // Fill count the DUT samples at the next edge
            seen_count      = pfb_status.count;
        end
    end

    ////////////////////////////////////////
    // End of run and watchdog
    ////////////////////////////////////////
    initial begin
        wait (run_finished);
        repeat (5) @(posedge clk_500MHz);
        if (pfb_writes != accepted)
            report_mismatch("pfb write count", pfb_writes, accepted);
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk_500MHz);
        report_failure("run did not finish before the watchdog limit");
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
